/* all.f */
+incdir+hw
hw/cur_buf_pkg.sv
hw/cur_fetch.sv
hw/cur_block_store.sv
hw/cur_row_select.sv
hw/cur_buffer.sv
dv/cur_buffer_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module cur_buffer_tb \
    -f all.f -o cur_buffer_sim \
    && ./obj_dir/cur_buffer_sim > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log 2>/dev/null && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* dv/cur_buffer_tb.sv */
// Testbench for the current-block buffer
// Memory answers one cycle after each accepted request and ready is random at about 70 %
// Pixel at byte address a is the low byte of a XOR 8'h5a, so blocks repeat every 256 bytes
`timescale 1ns/100ps
`include "cur_buf_cfg.svh"

module cur_buffer_tb;
    import cur_buf_pkg::*;

    localparam int N_ADV   = 6;
    localparam int MAX_GAP = 5;
    // Rough cycles per block at 70 % ready, plus the fetch restart
    localparam int BLK_CYC = WORDS_PER_BLOCK * 10 / 7 + 4;
    localparam int LIMIT   = 2 * (8 + (N_ADV + 2) * BLK_CYC + N_ADV * (MAX_GAP + 9) + 8);

    logic      clk;
    logic      rst           = 1'b1;
    logic      mem_req_ready = 1'b0;
    logic      mem_rsp_valid = 1'b0;
    mem_word_t mem_rsp_data  = '0;
    logic      advance_valid = 1'b0;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      advance_ready;
    block_t    rows;
    logic      rows_valid;

    int          cyc = 0;
    bit          ready_pat [LIMIT];
    int          gap_pat [N_ADV];
    int          err_cnt [5];
    string       test_name [5] = '{"addresses", "reset and first load", "staggered switch",
                                   "advance readiness", "steady state"};
    logic [31:0] expect_addr = '0;
    int          req_cnt     = 0;
    int          rsp_total   = 0;
    int          adv_cnt     = 0;
    // Last row index already on the new block
    // Stays at -1 while no switch runs
    int          sw_k        = -1;
    bit          rv_seen     = 1'b0;
    bit          first_done  = 1'b0;

    cur_buffer cur_buffer_i (
        .clk           (clk),
        .rst           (rst),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .advance_valid (advance_valid),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .advance_ready (advance_ready),
        .rows          (rows),
        .rows_valid    (rows_valid)
    );

    function automatic pixel_t pix_at(logic [31:0] addr);
        return addr[7:0] ^ 8'h5a;
    endfunction

    function automatic mem_word_t word_at(logic [31:0] addr);
        mem_word_t w;
        for (int i = 0; i < `CUR_WORD_PIX; i++) begin
            w[i] = pix_at(addr + i);
        end
        return w;
    endfunction

    function automatic row_t block_row(int blk, int r);
        row_t row;
        for (int p = 0; p < `CUR_BLK_DIM; p++) begin
            row[p] = pix_at(32'(`CUR_BLK_DIM * (`CUR_BLK_DIM * blk + r) + p));
        end
        return row;
    endfunction

    task automatic flag_error(int test, string msg);
        err_cnt[test - 1]++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic print_test(int test);
        $display("test %0d %s: %0d errors", test, test_name[test - 1], err_cnt[test - 1]);
    endtask

    task automatic check_row(int test, int r, int blk);
        assert (rows[r] == block_row(blk, r))
            else flag_error(test, $sformatf("row %0d is %h, expected block %0d",
                                            r, rows[r], blk));
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        mem_req_ready <= ready_pat[cyc % LIMIT];
    end

    // Fixed-latency memory that answers every accepted request
    always @(posedge clk) begin
        mem_rsp_valid <= !rst && mem_req_valid && mem_req_ready;
        mem_rsp_data  <= word_at(mem_req.addr);
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else flag_error(1, "stalled request was dropped or changed");

    assert property (@(posedge clk)
        (rst && cyc > 0) |-> (!mem_req_valid && !rows_valid && !advance_ready))
        else flag_error(2, "output handshake high during reset");

    always @(posedge clk) begin : monitor
        int blk;
        bit exp_ready;

        if (!rst) begin
            if (mem_req_valid && mem_req_ready) begin
                assert (mem_req.addr == expect_addr)
                    else flag_error(1, $sformatf("request address %h, expected %h",
                                                 mem_req.addr, expect_addr));
                expect_addr += 32'd4;
                req_cnt++;
            end

            assert (rows_valid == rv_seen)
                else flag_error(2, $sformatf("rows_valid is %b, expected %b",
                                             rows_valid, rv_seen));

            // Back bank full and no switch running
            exp_ready = rv_seen && sw_k < 0 && rsp_total >= WORDS_PER_BLOCK * (adv_cnt + 2);
            assert (advance_ready == exp_ready)
                else flag_error(4, $sformatf("advance_ready is %b, expected %b",
                                             advance_ready, exp_ready));

            if (rv_seen && !first_done) begin
                for (int r = 0; r < `CUR_BLK_DIM; r++) begin
                    check_row(2, r, 0);
                end
                first_done = 1'b1;
                print_test(2);
            end else if (rv_seen && sw_k >= 0) begin
                for (int r = 0; r < `CUR_BLK_DIM; r++) begin
                    blk = (r <= sw_k) ? adv_cnt : adv_cnt - 1;
                    check_row(3, r, blk);
                end
            end else if (rv_seen) begin
                for (int r = 0; r < `CUR_BLK_DIM; r++) begin
                    check_row(5, r, adv_cnt);
                end
            end

            // Model state moves on after this cycle's checks
            if (sw_k == `CUR_BLK_DIM - 1) begin
                sw_k = -1;
            end else if (sw_k >= 0) begin
                sw_k++;
            end
            if (advance_valid && advance_ready) begin
                adv_cnt++;
                sw_k = 0;
            end
            if (mem_rsp_valid) begin
                rsp_total++;
                if (rsp_total == WORDS_PER_BLOCK) begin
                    rv_seen = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus and report
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int total;

        void'($urandom(32'hd1d4d0ce));
        for (int i = 0; i < LIMIT; i++) begin
            ready_pat[i] = ($urandom % 10) < 7;
        end
        for (int i = 0; i < N_ADV; i++) begin
            gap_pat[i] = int'($urandom % (MAX_GAP + 1));
        end

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Cold boot loads block 0 and prefetches block 1 on its own
        do @(posedge clk); while (!rows_valid);

        for (int i = 0; i < N_ADV; i++) begin
            if (gap_pat[i] != 0) begin
                advance_valid <= 1'b0;
                repeat (gap_pat[i]) @(posedge clk);
            end
            // A zero gap keeps valid high straight through
            advance_valid <= 1'b1;
            do @(posedge clk); while (!advance_ready);
        end
        advance_valid <= 1'b0;

        // Last prefetch must land too
        do @(posedge clk); while (!advance_ready);
        repeat (4) @(posedge clk);

        // Every offered advance must have moved the display on by one block
        for (int r = 0; r < `CUR_BLK_DIM; r++) begin
            check_row(4, r, N_ADV);
        end
        if (!first_done) begin
            flag_error(2, "first block was never checked");
            print_test(2);
        end
        print_test(1);
        print_test(3);
        print_test(4);
        print_test(5);

        total = err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] + err_cnt[4];
        $display("tests 5, requests %0d, advances %0d, errors %0d", req_cnt, adv_cnt, total);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        while (cyc < LIMIT) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* hw/cur_buffer.sv */
// Current-block buffer for block-matching motion estimation
// Memory answers each accepted request exactly one cycle later, in order
// rows is meaningful only while rows_valid is high
`timescale 1ns/100ps

module cur_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_req_ready,
    input  logic                   mem_rsp_valid,
    input  cur_buf_pkg::mem_word_t mem_rsp_data,
    input  logic                   advance_valid,
    output logic                   mem_req_valid,
    output cur_buf_pkg::mem_req_t  mem_req,
    output logic                   advance_ready,
    output cur_buf_pkg::block_t    rows,
    output logic                   rows_valid
);
    import cur_buf_pkg::*;

    logic   fetch_start;
    logic   swap;
    logic   front_bank;
    logic   switching;
    block_t bank0;
    block_t bank1;

    cur_fetch cur_fetch_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_start   (fetch_start),
        .mem_req_ready (mem_req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req)
    );

    cur_block_store cur_block_store_i (
        .clk           (clk),
        .rst           (rst),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .advance_valid (advance_valid),
        .switching     (switching),
        .advance_ready (advance_ready),
        .fetch_start   (fetch_start),
        .swap          (swap),
        .front_bank    (front_bank),
        .rows_valid    (rows_valid),
        .bank0         (bank0),
        .bank1         (bank1)
    );

    cur_row_select cur_row_select_i (
        .clk        (clk),
        .rst        (rst),
        .swap       (swap),
        .front_bank (front_bank),
        .bank0      (bank0),
        .bank1      (bank1),
        .rows       (rows),
        .switching  (switching)
    );

endmodule

/* hw/cur_row_select.sv */
// Staggered per-row bank select
// On a swap, row r moves to the new front bank r cycles after the swap pulse
// The front bank must already be flipped in the swap cycle
`timescale 1ns/100ps
`include "cur_buf_cfg.svh"

module cur_row_select (
    input  logic                clk,
    input  logic                rst,
    input  logic                swap,
    input  logic                front_bank,
    input  cur_buf_pkg::block_t bank0,
    input  cur_buf_pkg::block_t bank1,
    output cur_buf_pkg::block_t rows,
    output logic                switching
);
    import cur_buf_pkg::*;

    // Highest row already on the new bank; zero while idle
    row_idx_t stag_cnt;
    logic     stag_active;

    // The swap cycle itself counts as the first switching cycle
    assign switching = swap || stag_active;

    always_ff @(posedge clk) begin
        if (rst) begin
            stag_active <= 1'b0;
            stag_cnt    <= '0;
        end else if (swap) begin
            stag_active <= 1'b1;
            stag_cnt    <= row_idx_t'(1);
        end else if (stag_active) begin
            if (stag_cnt == row_idx_t'(`CUR_BLK_DIM - 1)) begin
                stag_active <= 1'b0;
                stag_cnt    <= '0;
            end else begin
                stag_cnt <= stag_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        logic take_front;
        logic use_bank1;

        take_front = 1'b1;
        use_bank1  = 1'b0;
        for (int r = 0; r < `CUR_BLK_DIM; r++) begin
            take_front = !switching || (row_idx_t'(r) <= stag_cnt);
            use_bank1  = take_front ? front_bank : ~front_bank;
            rows[r]    = use_bank1 ? bank1[r] : bank0[r];
        end
    end

endmodule

/* hw/cur_block_store.sv */
// Two block banks with write pointer, bank swap and advance handshake
// Responses must come in request order; the write pointer wraps per block
// Advance is taken only with a full back bank and no row switch running
`timescale 1ns/100ps
`include "cur_buf_cfg.svh"

module cur_block_store (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_rsp_valid,
    input  cur_buf_pkg::mem_word_t mem_rsp_data,
    input  logic                   advance_valid,
    input  logic                   switching,
    output logic                   advance_ready,
    output logic                   fetch_start,
    output logic                   swap,
    output logic                   front_bank,
    output logic                   rows_valid,
    output cur_buf_pkg::block_t    bank0,
    output cur_buf_pkg::block_t    bank1
);
    import cur_buf_pkg::*;

    word_idx_t wr_ptr;
    row_idx_t  wr_row;
    logic      wr_half;
    logic      last_word;
    logic      adv_fire;
    logic      back_full;
    logic      boot;
    logic      refetch;

    // Two words per row, even word in the low half
    assign wr_row    = wr_ptr[$bits(word_idx_t)-1:1];
    assign wr_half   = wr_ptr[0];
    assign last_word = mem_rsp_valid && (wr_ptr == word_idx_t'(WORDS_PER_BLOCK - 1));
    assign adv_fire  = advance_valid && advance_ready;

    assign advance_ready = back_full && !switching;
    assign fetch_start   = boot || refetch;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            boot       <= 1'b1;
            refetch    <= 1'b0;
            swap       <= 1'b0;
            front_bank <= 1'b1;
            back_full  <= 1'b0;
            rows_valid <= 1'b0;
            wr_ptr     <= '0;
        end else begin
            boot    <= 1'b0;
            swap    <= adv_fire;
            // Cold load done or advance taken, next block goes to the free bank
            refetch <= adv_fire || (last_word && !rows_valid);

            if (mem_rsp_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (last_word) begin
                if (!rows_valid) begin
                    // First block becomes the front bank without a stagger
                    rows_valid <= 1'b1;
                    front_bank <= ~front_bank;
                end else begin
                    back_full <= 1'b1;
                end
            end

            if (adv_fire) begin
                front_bank <= ~front_bank;
                back_full  <= 1'b0;
            end
        end
    end

    // Writes always go to the bank that is not in front
    always_ff @(posedge clk) begin
        if (mem_rsp_valid) begin
            if (front_bank) begin
                bank0[wr_row][wr_half*`CUR_WORD_PIX +: `CUR_WORD_PIX] <= mem_rsp_data;
            end else begin
                bank1[wr_row][wr_half*`CUR_WORD_PIX +: `CUR_WORD_PIX] <= mem_rsp_data;
            end
        end
    end

endmodule

/* hw/cur_fetch.sv */
// Sequential word fetch, one block of requests per start pulse
// The byte address runs on across blocks and only returns to 0 on reset
// A start pulse must not arrive while a block is still being requested
`timescale 1ns/100ps
`include "cur_buf_cfg.svh"

module cur_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_start,
    input  logic                  mem_req_ready,
    output logic                  mem_req_valid,
    output cur_buf_pkg::mem_req_t mem_req
);
    import cur_buf_pkg::*;

    // Bytes per memory word
    localparam logic [`CUR_ADDR_W-1:0] ADDR_STEP =
        `CUR_ADDR_W'(`CUR_WORD_PIX * `CUR_PIX_W / 8);

    // Words still to be accepted after the current one
    word_idx_t remain;
    logic      req_fire;

    assign req_fire = mem_req_valid && mem_req_ready;

    // ------------------------------------------------------------------------
    // Request FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req_valid <= 1'b0;
            mem_req.addr  <= '0;
            remain        <= '0;
        end else begin
            if (fetch_start) begin
                mem_req_valid <= 1'b1;
                remain        <= word_idx_t'(WORDS_PER_BLOCK - 1);
            end else if (req_fire) begin
                if (remain == '0) begin
                    mem_req_valid <= 1'b0;
                end else begin
                    remain <= remain - 1'b1;
                end
            end

            // Address only moves on acceptance, so it holds under back-pressure
            if (req_fire) begin
                mem_req.addr <= mem_req.addr + ADDR_STEP;
            end
        end
    end

endmodule

/* hw/cur_buf_pkg.sv */
// Types shared by the current-block buffer
// Pixel order is little endian throughout: lowest address in the lowest byte

`include "cur_buf_cfg.svh"

package cur_buf_pkg;

    typedef logic [`CUR_PIX_W-1:0] pixel_t;

    // Four pixels, lowest byte address at index 0
    typedef pixel_t [`CUR_WORD_PIX-1:0] mem_word_t;

    // One block row, pixel 0 at index 0
    typedef pixel_t [`CUR_BLK_DIM-1:0] row_t;

    // Whole block, row 0 at index 0
    typedef row_t [`CUR_BLK_DIM-1:0] block_t;

    typedef struct packed {
        logic [`CUR_ADDR_W-1:0] addr;
    } mem_req_t;

    localparam int WORDS_PER_BLOCK = `CUR_BLK_DIM * `CUR_BLK_DIM / `CUR_WORD_PIX;

    typedef logic [$clog2(WORDS_PER_BLOCK)-1:0] word_idx_t;
    typedef logic [$clog2(`CUR_BLK_DIM)-1:0] row_idx_t;

endpackage

/* hw/cur_buf_cfg.svh */
// Geometry of the current-block buffer
// The fetch and store logic assume a row holds a whole number of memory words
// and that a block holds a power-of-two number of words

`ifndef CUR_BUF_CFG_SVH
`define CUR_BUF_CFG_SVH

// Bits per pixel
`define CUR_PIX_W 8

// Rows per block, also pixels per row
`define CUR_BLK_DIM 8

// Pixels carried by one memory word
`define CUR_WORD_PIX 4

// Memory byte address width
`define CUR_ADDR_W 32

`endif
